/* logic/hps_pkg.sv */
// command codes, bus widths, ps2 port count and ps2 timing constants
package hps_pkg;

	////////////////////////////////////////////////////////////////////////////
	// host command codes
	////////////////////////////////////////////////////////////////////////////

	localparam logic [15:0] CMD_JOY0     = 16'h0002;
	localparam logic [15:0] CMD_JOY1     = 16'h0003;
	localparam logic [15:0] CMD_MOUSE    = 16'h0004;
	localparam logic [15:0] CMD_KBD      = 16'h0005;
	localparam logic [15:0] CMD_STATUS   = 16'h001E;
	localparam logic [15:0] CMD_PS2_READ = 16'h0021;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int WORD_W     = 16;
	localparam int JOY_W      = 32;
	localparam int STATUS_W   = 64;
	// word index within one command, saturates
	localparam int BYTE_CNT_W = 10;

	////////////////////////////////////////////////////////////////////////////
	// ps2 ports
	////////////////////////////////////////////////////////////////////////////

	localparam int PS2_NUM   = 2;
	localparam int PS2_KBD   = 0;
	localparam int PS2_MOUSE = 1;

	// queue holds 2**PS2_FIFO_BITS bytes
	localparam int PS2_FIFO_BITS  = 5;
	// clk_sys cycles per half bit clock
	localparam int PS2_DIV        = 8;
	// idle bit-clock rises before a new frame may start
	localparam int PS2_START_WAIT = 4;

endpackage

/* logic/hps_if.sv */
// host frame interface and ps2 port interface
`timescale 1ns/10ps

// one host command as seen by the decoder and the readback block
interface host_frame_if;
	import hps_pkg::*;

	// copy of io_enable
	logic                  active;
	logic                  strobe;
	logic [WORD_W-1:0]     word;
	// command code latched from word 0
	logic [WORD_W-1:0]     cmd;
	logic [BYTE_CNT_W-1:0] byte_cnt;

	modport decoder (
		output active,
		output strobe,
		output word,
		output cmd,
		output byte_cnt
	);

	modport reader (
		input active,
		input strobe,
		input word,
		input cmd,
		input byte_cnt
	);
endinterface

// byte path into and out of one ps2 device
interface ps2_port_if;
	// host to queue
	logic [7:0] wdata;
	logic       we;
	// {valid, byte} received from the ps2 lines
	logic [8:0] rdata;
	logic       rd;

	modport feed (
		output wdata,
		output we
	);

	modport dev (
		input  wdata,
		input  we,
		input  rd,
		output rdata
	);

	modport drain (
		input  rdata,
		output rd
	);
endinterface

/* logic/host_cmd_decoder.sv */
// host command decoder: word counter, joystick and status registers, ps2 queue feed
`timescale 1ns/10ps

module host_cmd_decoder (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          io_enable,
	input  logic                          io_strobe,
	input  logic [hps_pkg::WORD_W-1:0]    io_din,
	host_frame_if.decoder                 frame,
	ps2_port_if.feed                      ps2 [hps_pkg::PS2_NUM],
	output logic [hps_pkg::JOY_W-1:0]     joystick_0,
	output logic [hps_pkg::JOY_W-1:0]     joystick_1,
	output logic [hps_pkg::STATUS_W-1:0]  status
);
	import hps_pkg::*;

	// strobe of any word after the command code
	logic data_stb;

	assign frame.active = io_enable;
	assign frame.strobe = io_strobe;
	assign frame.word   = io_din;

	assign data_stb = frame.active && frame.strobe && (frame.byte_cnt != '0);

	////////////////////////////////////////////////////////////////////////////
	// command latch and word index
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			frame.cmd      <= '0;
			frame.byte_cnt <= '0;
		end else if (!frame.active) begin
			frame.cmd      <= '0;
			frame.byte_cnt <= '0;
		end else if (frame.strobe) begin
			if (frame.byte_cnt == '0)
				frame.cmd <= frame.word;
			// stays at all ones on long commands
			if (~&frame.byte_cnt)
				frame.byte_cnt <= frame.byte_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// joysticks and status word, low half first
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (data_stb) begin
			case (frame.cmd)
				CMD_JOY0: begin
					if (frame.byte_cnt == BYTE_CNT_W'(1))
						joystick_0[WORD_W-1:0] <= frame.word;
					else if (frame.byte_cnt == BYTE_CNT_W'(2))
						joystick_0[JOY_W-1:WORD_W] <= frame.word;
				end
				CMD_JOY1: begin
					if (frame.byte_cnt == BYTE_CNT_W'(1))
						joystick_1[WORD_W-1:0] <= frame.word;
					else if (frame.byte_cnt == BYTE_CNT_W'(2))
						joystick_1[JOY_W-1:WORD_W] <= frame.word;
				end
				CMD_STATUS: begin
					case (frame.byte_cnt)
						BYTE_CNT_W'(1): status[0*WORD_W +: WORD_W] <= frame.word;
						BYTE_CNT_W'(2): status[1*WORD_W +: WORD_W] <= frame.word;
						BYTE_CNT_W'(3): status[2*WORD_W +: WORD_W] <= frame.word;
						BYTE_CNT_W'(4): status[3*WORD_W +: WORD_W] <= frame.word;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// ps2 queue feed, one cycle after the data strobe
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ps2[PS2_KBD].we   <= 1'b0;
			ps2[PS2_MOUSE].we <= 1'b0;
		end else begin
			ps2[PS2_KBD].we   <= data_stb && (frame.cmd == CMD_KBD);
			ps2[PS2_MOUSE].we <= data_stb && (frame.cmd == CMD_MOUSE);
		end
	end

	// only the low byte goes on the wire
	always_ff @(posedge clk_sys) begin
		if (data_stb) begin
			ps2[PS2_KBD].wdata   <= frame.word[7:0];
			ps2[PS2_MOUSE].wdata <= frame.word[7:0];
		end
	end

endmodule

/* logic/ps2_bit_clock.sv */
// ps2 bit clock divider with rise and fall strobes
`timescale 1ns/10ps

module ps2_bit_clock (
	input  logic clk_sys,
	input  logic reset,
	output logic bit_rise,
	output logic bit_fall
);
	import hps_pkg::*;

	logic [$clog2(PS2_DIV)-1:0] div_cnt;
	logic                       bit_clk;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			div_cnt  <= '0;
			bit_clk  <= 1'b0;
			bit_rise <= 1'b0;
			bit_fall <= 1'b0;
		end else begin
			bit_rise <= 1'b0;
			bit_fall <= 1'b0;
			if (div_cnt == ($clog2(PS2_DIV))'(PS2_DIV - 1)) begin
				div_cnt  <= '0;
				bit_clk  <= ~bit_clk;
				// strobe marks the edge the clock is about to take
				bit_rise <= ~bit_clk;
				bit_fall <= bit_clk;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

/* logic/ps2_port.sv */
// ps2 device: byte queue, 11-bit frame transmitter and host request receiver
`timescale 1ns/10ps

module ps2_port (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     bit_rise,
	input  logic     bit_fall,
	ps2_port_if.dev  bus,
	input  logic     ps2_clk_in,
	input  logic     ps2_dat_in,
	output logic     ps2_clk_out,
	output logic     ps2_dat_out
);
	import hps_pkg::*;

	// transmit queue, pointers carry one extra wrap bit
	logic [7:0]             fifo_mem [0:(1 << PS2_FIFO_BITS) - 1];
	logic [PS2_FIFO_BITS:0] wptr;
	logic [PS2_FIFO_BITS:0] rptr;
	logic                   fifo_empty;
	logic                   fifo_full;

	// transmitter, state 0 is idle, 1..11 walk through the frame
	logic [3:0]                            tx_state;
	logic [7:0]                            tx_byte;
	logic                                  tx_parity;
	logic [$clog2(PS2_START_WAIT + 1)-1:0] idle_cnt;
	logic                                  idle_done;
	logic                                  lines_idle;

	// receiver, 0 idle, 1 request seen, 2 data, 3 wait stop, 4 ack
	logic [2:0] rx_state;
	logic [3:0] rx_cnt;
	logic [7:0] rx_byte;
	logic       rx_valid;

	// synchronizers on the host side lines
	logic clk_s1;
	logic clk_s2;
	logic dat_s1;

	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[PS2_FIFO_BITS] != rptr[PS2_FIFO_BITS]) &&
	                    (wptr[PS2_FIFO_BITS-1:0] == rptr[PS2_FIFO_BITS-1:0]);
	assign lines_idle = clk_s2 && clk_s1 && dat_s1;
	assign idle_done  = (idle_cnt == ($clog2(PS2_START_WAIT + 1))'(PS2_START_WAIT));

	assign bus.rdata = {rx_valid, rx_byte};

	always_ff @(posedge clk_sys) begin
		if (bus.we)
			fifo_mem[wptr[PS2_FIFO_BITS-1:0]] <= bus.wdata;
	end

	////////////////////////////////////////////////////////////////////////////
	// line control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wptr        <= '0;
			rptr        <= '0;
			tx_state    <= 4'd0;
			tx_byte     <= 8'd0;
			tx_parity   <= 1'b0;
			idle_cnt    <= '0;
			rx_state    <= 3'd0;
			rx_cnt      <= 4'd0;
			rx_byte     <= 8'd0;
			rx_valid    <= 1'b0;
			clk_s1      <= 1'b1;
			clk_s2      <= 1'b1;
			dat_s1      <= 1'b1;
			ps2_clk_out <= 1'b1;
			ps2_dat_out <= 1'b1;
		end else begin
			clk_s1 <= ps2_clk_in;
			clk_s2 <= clk_s1;
			dat_s1 <= ps2_dat_in;

			if (bus.we)
				wptr <= wptr + 1'b1;
			if (bus.rd)
				rx_valid <= 1'b0;

			// host released clock with data held low: request to send
			if (rx_state == 3'd0 && tx_state == 4'd0 && !clk_s2 && clk_s1 && !dat_s1) begin
				rx_state    <= 3'd1;
				ps2_dat_out <= 1'b1;
			end

			if (bit_rise) begin
				ps2_clk_out <= 1'b1;
				if (rx_state != 3'd0) begin
					case (rx_state)
						3'd1: begin
							rx_state <= 3'd2;
							rx_cnt   <= 4'd0;
						end
						3'd2: begin
							// eight data bits LSB first, the ninth rise is parity
							if (rx_cnt < 4'd8)
								rx_byte <= {dat_s1, rx_byte[7:1]};
							else
								rx_state <= 3'd3;
							rx_cnt <= rx_cnt + 1'b1;
						end
						3'd3: begin
							if (dat_s1) begin
								rx_state    <= 3'd4;
								ps2_dat_out <= 1'b0;
							end
						end
						default: begin
							// end of ack bit
							ps2_dat_out <= 1'b1;
							rx_valid    <= 1'b1;
							rx_state    <= 3'd0;
						end
					endcase
				end else if (tx_state == 4'd0) begin
					if (!lines_idle)
						idle_cnt <= '0;
					else if (!idle_done)
						idle_cnt <= idle_cnt + 1'b1;
					if (lines_idle && idle_done && !fifo_empty) begin
						tx_byte     <= fifo_mem[rptr[PS2_FIFO_BITS-1:0]];
						tx_parity   <= ~^fifo_mem[rptr[PS2_FIFO_BITS-1:0]];
						rptr        <= rptr + 1'b1;
						idle_cnt    <= '0;
						tx_state    <= 4'd1;
						// start bit
						ps2_dat_out <= 1'b0;
					end
				end else begin
					if (tx_state <= 4'd8) begin
						ps2_dat_out <= tx_byte[0];
						tx_byte     <= {1'b0, tx_byte[7:1]};
					end else if (tx_state == 4'd9) begin
						ps2_dat_out <= tx_parity;
					end else if (tx_state == 4'd10) begin
						ps2_dat_out <= 1'b1;
					end
					tx_state <= (tx_state == 4'd11) ? 4'd0 : tx_state + 1'b1;
				end
			end else if (bit_fall) begin
				ps2_clk_out <= (tx_state == 4'd0) && (rx_state < 3'd2);
			end
		end
	end

	// the host has no back-pressure, so a push into a full queue loses a byte
	a_no_push_full: assert property (@(posedge clk_sys) disable iff (reset)
		bus.we |-> !fifo_full);

	a_tx_rx_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!((tx_state != 4'd0) && (rx_state != 3'd0)));

endmodule

/* logic/host_readback.sv */
// host read word for the ps2 readback command
`timescale 1ns/10ps

module host_readback (
	input  logic                        clk_sys,
	input  logic                        reset,
	host_frame_if.reader                frame,
	ps2_port_if.drain                   ps2 [hps_pkg::PS2_NUM],
	output logic [hps_pkg::WORD_W-1:0]  io_dout
);
	import hps_pkg::*;

	logic [WORD_W-1:0] dout_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dout_q             <= '0;
			ps2[PS2_KBD].rd   <= 1'b0;
			ps2[PS2_MOUSE].rd <= 1'b0;
		end else begin
			ps2[PS2_KBD].rd   <= 1'b0;
			ps2[PS2_MOUSE].rd <= 1'b0;
			if (!frame.active) begin
				dout_q <= '0;
			end else if (frame.strobe) begin
				// every word answers 0 unless it is a readback slot
				dout_q <= '0;
				if (frame.cmd == CMD_PS2_READ) begin
					if (frame.byte_cnt == BYTE_CNT_W'(1)) begin
						dout_q          <= {{(WORD_W - 9){1'b0}}, ps2[PS2_KBD].rdata};
						ps2[PS2_KBD].rd <= 1'b1;
					end else if (frame.byte_cnt == BYTE_CNT_W'(2)) begin
						dout_q            <= {{(WORD_W - 9){1'b0}}, ps2[PS2_MOUSE].rdata};
						ps2[PS2_MOUSE].rd <= 1'b1;
					end
				end
			end
		end
	end

	// bus reads 0 for as long as no command is open
	assign io_dout = frame.active ? dout_q : '0;

	a_one_rd: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({ps2[PS2_MOUSE].rd, ps2[PS2_KBD].rd}));

endmodule

/* logic/hps_io_lite.sv */
// top level of the host i/o bridge: decoder, bit clock, ps2 ports and readback
`timescale 1ns/10ps

module hps_io_lite (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          io_enable,
	input  logic                          io_strobe,
	input  logic [hps_pkg::WORD_W-1:0]    io_din,
	output logic [hps_pkg::WORD_W-1:0]    io_dout,
	output logic [hps_pkg::JOY_W-1:0]     joystick_0,
	output logic [hps_pkg::JOY_W-1:0]     joystick_1,
	output logic [hps_pkg::STATUS_W-1:0]  status,
	output logic [hps_pkg::PS2_NUM-1:0]   ps2_clk_out,
	output logic [hps_pkg::PS2_NUM-1:0]   ps2_dat_out,
	input  logic [hps_pkg::PS2_NUM-1:0]   ps2_clk_in,
	input  logic [hps_pkg::PS2_NUM-1:0]   ps2_dat_in
);
	import hps_pkg::*;

	// shared bit clock strobes
	logic bit_rise;
	logic bit_fall;

	host_frame_if frame ();
	ps2_port_if   ps2_bus [PS2_NUM] ();

	host_cmd_decoder u_decoder (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_enable  (io_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.frame      (frame),
		.ps2        (ps2_bus),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status)
	);

	ps2_bit_clock u_bit_clock (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bit_rise (bit_rise),
		.bit_fall (bit_fall)
	);

	// keyboard is port 0, mouse is port 1
	for (genvar i = 0; i < PS2_NUM; i++) begin : g_port
		ps2_port u_port (
			.clk_sys     (clk_sys),
			.reset       (reset),
			.bit_rise    (bit_rise),
			.bit_fall    (bit_fall),
			.bus         (ps2_bus[i]),
			.ps2_clk_in  (ps2_clk_in[i]),
			.ps2_dat_in  (ps2_dat_in[i]),
			.ps2_clk_out (ps2_clk_out[i]),
			.ps2_dat_out (ps2_dat_out[i])
		);
	end

	host_readback u_readback (
		.clk_sys (clk_sys),
		.reset   (reset),
		.frame   (frame),
		.ps2     (ps2_bus),
		.io_dout (io_dout)
	);

endmodule

/* verif/hps_io_checker.sv */
// ps2 frame decoder, expected byte queues and value compares of the testbench
`timescale 1ns/10ps

module hps_io_checker (
	input logic                          clk_sys,
	input logic                          reset,
	input logic [hps_pkg::PS2_NUM-1:0]   ps2_clk_out,
	input logic [hps_pkg::PS2_NUM-1:0]   ps2_dat_out,
	input logic [hps_pkg::PS2_NUM-1:0]   host_req,
	input logic [hps_pkg::WORD_W-1:0]    io_dout,
	input logic [hps_pkg::JOY_W-1:0]     joystick_0,
	input logic [hps_pkg::JOY_W-1:0]     joystick_1,
	input logic [hps_pkg::STATUS_W-1:0]  status
);
	import hps_pkg::*;

	// bytes the host has sent and that are still waiting for their frame
	logic [7:0] kbd_q [$];
	logic [7:0] mouse_q [$];

	int mismatch_cnt = 0;
	int frame_err_cnt = 0;

	// frame decode state per port
	logic [PS2_NUM-1:0] clk_prev;
	logic [PS2_NUM-1:0] dat_held;
	logic [10:0]        shift [PS2_NUM];
	int                 bit_cnt [PS2_NUM];

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
		if (got !== want) begin
			mismatch_cnt++;
			$display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, want);
		end
	endtask

	task automatic push_expected(input int port, input logic [7:0] b);
		if (port == PS2_KBD)
			kbd_q.push_back(b);
		else
			mouse_q.push_back(b);
	endtask

	function automatic int pending();
		return kbd_q.size() + mouse_q.size();
	endfunction

	task automatic expect_dout(input logic [15:0] want);
		compare("io_dout", 64'(io_dout), 64'(want));
	endtask

	task automatic expect_regs(input logic [31:0] j0, input logic [31:0] j1,
	                           input logic [63:0] st);
		compare("joystick_0", 64'(joystick_0), 64'(j0));
		compare("joystick_1", 64'(joystick_1), 64'(j1));
		compare("status", status, st);
	endtask

	task automatic expect_idle();
		compare("ps2_clk_out", 64'(ps2_clk_out), 64'({PS2_NUM{1'b1}}));
		compare("ps2_dat_out", 64'(ps2_dat_out), 64'({PS2_NUM{1'b1}}));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// start 0, data LSB first, odd parity and stop 1 on every frame
	////////////////////////////////////////////////////////////////////////////

	task automatic close_frame(input int port, input logic [10:0] f);
		string      name;
		logic [7:0] want;
		if (port == PS2_KBD)
			name = "keyboard";
		else
			name = "mouse";
		if (f[0] !== 1'b0) begin
			frame_err_cnt++;
			$display("%s frame ending at %0t has a start bit that is not 0", name, $time);
		end
		// data and parity together carry an odd number of ones
		if (^f[9:1] !== 1'b1) begin
			frame_err_cnt++;
			$display("%s frame ending at %0t has wrong parity", name, $time);
		end
		if (f[10] !== 1'b1) begin
			frame_err_cnt++;
			$display("%s frame ending at %0t has a stop bit that is not 1", name, $time);
		end
		if ((port == PS2_KBD && kbd_q.size() == 0) ||
		    (port == PS2_MOUSE && mouse_q.size() == 0)) begin
			frame_err_cnt++;
			$display("%s port sent a frame at %0t that nobody asked for", name, $time);
		end else begin
			want = (port == PS2_KBD) ? kbd_q.pop_front() : mouse_q.pop_front();
			compare({"ps2 ", name, " byte"}, 64'(f[8:1]), 64'(want));
		end
	endtask

	// the bit of each period is the one held while the clock is low
	always @(negedge clk_sys) begin
		for (int p = 0; p < PS2_NUM; p++) begin
			if (reset || host_req[p]) begin
				bit_cnt[p] = 0;
			end else if (!ps2_clk_out[p]) begin
				dat_held[p] = ps2_dat_out[p];
			end else if (!clk_prev[p]) begin
				shift[p][bit_cnt[p]] = dat_held[p];
				bit_cnt[p]++;
				if (bit_cnt[p] == 11) begin
					close_frame(p, shift[p]);
					bit_cnt[p] = 0;
				end
			end
			clk_prev[p] = ps2_clk_out[p];
		end
	end

endmodule

/* verif/tb_hps_io.sv */
// testbench top: clock, reset, random host commands, ps2 host requests and model
`timescale 1ns/10ps

module tb_hps_io;
	import hps_pkg::*;

	logic                clk_sys = 1'b0;
	logic                reset;
	logic                io_enable;
	logic                io_strobe;
	logic [WORD_W-1:0]   io_din;
	logic [WORD_W-1:0]   io_dout;
	logic [JOY_W-1:0]    joystick_0;
	logic [JOY_W-1:0]    joystick_1;
	logic [STATUS_W-1:0] status;
	logic [PS2_NUM-1:0]  ps2_clk_out;
	logic [PS2_NUM-1:0]  ps2_dat_out;
	logic [PS2_NUM-1:0]  ps2_clk_in;
	logic [PS2_NUM-1:0]  ps2_dat_in;
	// marks a host to device transfer, the checker ignores that port meanwhile
	logic [PS2_NUM-1:0]  host_req;

	// model state
	logic [JOY_W-1:0]    exp_joy0 = '0;
	logic [JOY_W-1:0]    exp_joy1 = '0;
	logic [STATUS_W-1:0] exp_status = '0;
	logic [PS2_NUM-1:0]  rx_valid = '0;
	logic [7:0]          rx_byte [PS2_NUM] = '{8'h00, 8'h00};

	logic [15:0] words [0:9];
	logic [31:0] rng_state = 32'hde22adc6;
	int          num_rounds = 6;
	int          cycle_cnt = 0;
	int          cycle_limit;

	always #2 clk_sys = ~clk_sys;

	hps_io_lite UUT (
		.clk_sys(clk_sys), .reset(reset), .io_enable(io_enable), .io_strobe(io_strobe),
		.io_din(io_din), .io_dout(io_dout), .joystick_0(joystick_0),
		.joystick_1(joystick_1), .status(status), .ps2_clk_out(ps2_clk_out),
		.ps2_dat_out(ps2_dat_out), .ps2_clk_in(ps2_clk_in), .ps2_dat_in(ps2_dat_in)
	);

	hps_io_checker chk (
		.clk_sys(clk_sys), .reset(reset), .ps2_clk_out(ps2_clk_out),
		.ps2_dat_out(ps2_dat_out), .host_req(host_req), .io_dout(io_dout),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .status(status)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	// readback slots 1 and 2 of the ps2 read command, everything else reads 0
	function automatic logic [15:0] expected_dout(input logic [15:0] cmd, input int idx);
		if (cmd == CMD_PS2_READ && idx == 1)
			return {7'b0, rx_valid[PS2_KBD], rx_byte[PS2_KBD]};
		if (cmd == CMD_PS2_READ && idx == 2)
			return {7'b0, rx_valid[PS2_MOUSE], rx_byte[PS2_MOUSE]};
		return 16'h0000;
	endfunction

	task automatic model_word(input logic [15:0] cmd, input int idx, input logic [15:0] w);
		if (idx != 0) begin
			case (cmd)
				CMD_JOY0: begin
					if (idx == 1) exp_joy0[15:0] = w;
					else if (idx == 2) exp_joy0[31:16] = w;
				end
				CMD_JOY1: begin
					if (idx == 1) exp_joy1[15:0] = w;
					else if (idx == 2) exp_joy1[31:16] = w;
				end
				CMD_STATUS: if (idx <= 4) exp_status[(idx - 1) * 16 +: 16] = w;
				CMD_KBD: chk.push_expected(PS2_KBD, w[7:0]);
				CMD_MOUSE: chk.push_expected(PS2_MOUSE, w[7:0]);
				CMD_PS2_READ: begin
					if (idx == 1) rx_valid[PS2_KBD] = 1'b0;
					else if (idx == 2) rx_valid[PS2_MOUSE] = 1'b0;
				end
				default: ;
			endcase
		end
	endtask

	// one host command of n words, each answer checked the cycle after its strobe
	task automatic send_command(input int n);
		logic [15:0] want;
		io_enable = 1'b1;
		for (int i = 0; i < n; i++) begin
			io_din = words[i];
			io_strobe = 1'b1;
			want = expected_dout(words[0], i);
			model_word(words[0], i, words[i]);
			@(posedge clk_sys);
			#1 io_strobe = 1'b0;
			chk.expect_dout(want);
			@(posedge clk_sys);
			#1;
		end
		io_enable = 1'b0;
		@(posedge clk_sys);
		#1 chk.expect_dout(16'h0000);
		chk.expect_regs(exp_joy0, exp_joy1, exp_status);
	endtask

	task automatic wait_drain();
		while (chk.pending() != 0)
			@(posedge clk_sys);
		repeat (2 * PS2_DIV) @(posedge clk_sys);
		#1;
	endtask

	// host to device byte: request, then one bit after each device clock fall
	task automatic host_send(input int port, input logic [7:0] data);
		logic [9:0] bits;
		logic       prev;
		int         falls;
		bits = {1'b1, ~^data, data};
		host_req[port] = 1'b1;
		ps2_clk_in[port] = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1 ps2_dat_in[port] = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1 ps2_clk_in[port] = 1'b1;
		prev = 1'b1;
		falls = 0;
		while (falls < 11) begin
			@(posedge clk_sys);
			#1;
			if (prev && !ps2_clk_out[port]) begin
				if (falls < 10)
					ps2_dat_in[port] = bits[falls];
				else
					chk.compare("ps2_dat_out ack", 64'(ps2_dat_out[port]), 64'd0);
				falls++;
			end
			prev = ps2_clk_out[port];
		end
		while (!ps2_clk_out[port]) begin
			@(posedge clk_sys);
			#1;
		end
		repeat (2) @(posedge clk_sys);
		#1 host_req[port] = 1'b0;
		rx_valid[port] = 1'b1;
		rx_byte[port] = data;
	endtask

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles", cycle_cnt);
			$display("errors: %0d mismatches, %0d frame errors",
			         chk.mismatch_cnt, chk.frame_err_cnt);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		logic [31:0] rnd;
		int          n;
		// 12 bit times per command, plus 16 bit times for every byte of both bursts
		cycle_limit = num_rounds * 7 * 12 * 2 * PS2_DIV
		            + num_rounds * 2 * 8 * 16 * 2 * PS2_DIV + 2000;
		reset = 1'b1;
		io_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		ps2_clk_in = '1;
		ps2_dat_in = '1;
		host_req = '0;
		repeat (3) @(posedge clk_sys);
		#1 reset = 1'b0;
		@(posedge clk_sys);
		#1;

		for (int r = 0; r < num_rounds; r++) begin
			draw(rnd);
			words[0] = rnd[0] ? CMD_JOY1 : CMD_JOY0;
			draw(rnd);
			words[1] = rnd[15:0];
			words[2] = rnd[31:16];
			send_command(3);

			words[0] = CMD_STATUS;
			for (int k = 1; k <= 4; k++) begin
				draw(rnd);
				words[k] = rnd[15:0];
			end
			send_command(5);

			// keyboard then mouse burst of 1 to 8 bytes
			for (int p = 0; p < PS2_NUM; p++) begin
				draw(rnd);
				n = 1 + int'(rnd[2:0]);
				words[0] = (p == PS2_KBD) ? CMD_KBD : CMD_MOUSE;
				for (int k = 1; k <= n; k++) begin
					draw(rnd);
					words[k] = rnd[15:0];
				end
				send_command(n + 1);
			end

			// any code below 0x40 with up to 3 data words
			draw(rnd);
			words[0] = {10'b0, rnd[5:0]};
			n = int'(rnd[7:6]);
			for (int k = 1; k <= n; k++) begin
				draw(rnd);
				words[k] = rnd[15:0];
			end
			send_command(n + 1);

			wait_drain();
			chk.expect_idle();

			draw(rnd);
			host_send(int'(rnd[0]), rnd[15:8]);
			words[0] = CMD_PS2_READ;
			for (int k = 1; k <= 4; k++) begin
				draw(rnd);
				words[k] = rnd[15:0];
			end
			send_command(5);
			send_command(5);
		end

		$display("errors: %0d mismatches, %0d frame errors",
		         chk.mismatch_cnt, chk.frame_err_cnt);
		if (chk.mismatch_cnt == 0 && chk.frame_err_cnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* compile.f */
logic/hps_pkg.sv
logic/hps_if.sv
logic/host_cmd_decoder.sv
logic/ps2_bit_clock.sv
logic/ps2_port.sv
logic/host_readback.sv
logic/hps_io_lite.sv
verif/hps_io_checker.sv
verif/tb_hps_io.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the result line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f compile.f --top-module tb_hps_io -Mdir obj_dir

sim_status=0
sim_out=$(./obj_dir/Vtb_hps_io) || sim_status=$?
printf '%s\n' "$sim_out"

if grep -qx "Finished with no errors" <<< "$sim_out"; then
	exit 0
fi
echo "simulation failed (exit status ${sim_status})"
exit 1
